/* rtl/bpu_config.svh */
`ifndef BPU_CONFIG_SVH
`define BPU_CONFIG_SVH

// word address without the byte offset
`define BPU_ADDR_WIDTH 30

// return stack entries
`define BPU_RAS_DEPTH 16

// direct-mapped table of 2**6 = 64 entries
`define BPU_BTB_IDX_BITS 6

`endif

/* rtl/bpu_pdc_pkg.sv */
`include "bpu_config.svh"

package bpu_pdc_pkg;

    typedef enum logic [1:0] {
        br_cond = 2'd0,
        br_jump = 2'd1,
        br_call = 2'd2,
        br_ret  = 2'd3
    } br_kind_e;

    typedef struct packed {
        logic                       valid;
        logic [`BPU_ADDR_WIDTH-1:0] pc;
    } pdc_req_t;

    typedef struct packed {
        logic                       hit;
        br_kind_e                   kind;
        logic                       taken;
        logic [`BPU_ADDR_WIDTH-1:0] next_pc;
    } pdc_pred_t;

    typedef struct packed {
        logic                       hit;
        br_kind_e                   kind;
        logic                       taken;
        logic [`BPU_ADDR_WIDTH-1:0] target;
    } btb_resp_t;

endpackage

/* rtl/bpu_ex_pkg.sv */
`include "bpu_config.svh"

package bpu_ex_pkg;

    // resolved branch coming back from execute
    typedef struct packed {
        logic                       valid;
        logic [`BPU_ADDR_WIDTH-1:0] pc;
        bpu_pdc_pkg::br_kind_e      kind;
        logic                       taken;   // actual outcome
        logic [`BPU_ADDR_WIDTH-1:0] target;  // actual target
        logic                       mis_pdc; // fetch guessed wrong
    } ex_upd_t;

endpackage

/* rtl/btb.sv */
`timescale 1ns/1ps
`include "bpu_config.svh"

module btb (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic [`BPU_ADDR_WIDTH-1:0] pc,
    input  bpu_ex_pkg::ex_upd_t        upd,
    output bpu_pdc_pkg::btb_resp_t     resp
);
    import bpu_pdc_pkg::*;

    localparam int AW      = `BPU_ADDR_WIDTH;
    localparam int IW      = `BPU_BTB_IDX_BITS;
    localparam int TW      = AW - IW;
    localparam int ENTRIES = 1 << IW;

    typedef struct packed {
        logic [TW-1:0] tag;
        br_kind_e      kind;
        logic [1:0]    ctr;    // 2-bit direction counter
        logic [AW-1:0] target;
    } btb_entry_t;

    btb_entry_t         tbl [ENTRIES];
    logic [ENTRIES-1:0] vld;

    logic [IW-1:0] rd_idx;
    logic [TW-1:0] rd_tag;
    btb_entry_t    rd_ent;
    logic          rd_hit;

    logic [IW-1:0] wr_idx;
    logic [TW-1:0] wr_tag;
    btb_entry_t    wr_ent;
    logic          wr_hit;
    logic          wr_en;
    logic [1:0]    ctr_next;

    // lookup
    assign rd_idx = pc[IW-1:0];
    assign rd_tag = pc[AW-1:IW];
    assign rd_ent = tbl[rd_idx];
    assign rd_hit = vld[rd_idx] && (rd_ent.tag == rd_tag);

    assign resp.hit    = rd_hit;
    assign resp.kind   = rd_hit ? rd_ent.kind : br_cond;
    assign resp.taken  = rd_hit && ((rd_ent.kind != br_cond) || rd_ent.ctr[1]);
    assign resp.target = rd_hit ? rd_ent.target : '0;

    // update
    assign wr_idx = upd.pc[IW-1:0];
    assign wr_tag = upd.pc[AW-1:IW];
    assign wr_ent = tbl[wr_idx];
    assign wr_hit = vld[wr_idx] && (wr_ent.tag == wr_tag);
    assign wr_en  = upd.valid && ((upd.kind != br_cond) || upd.taken);

    always_comb begin
        if (upd.taken) begin
            ctr_next = (wr_ent.ctr == 2'd3) ? 2'd3 : wr_ent.ctr + 2'd1;
        end else begin
            ctr_next = (wr_ent.ctr == 2'd0) ? 2'd0 : wr_ent.ctr - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            vld <= '0;
        end else if (wr_en && !wr_hit) begin
            vld[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upd.valid && wr_hit) begin
            if (wr_en) begin
                tbl[wr_idx].target <= upd.target;
                tbl[wr_idx].kind   <= upd.kind;
            end
            if (upd.kind == br_cond) begin
                tbl[wr_idx].ctr <= ctr_next;
            end
        end else if (wr_en) begin // install starts weakly taken
            tbl[wr_idx] <= '{tag: wr_tag, kind: upd.kind, ctr: 2'b10, target: upd.target};
        end
    end

endmodule

/* rtl/ras.sv */
`timescale 1ns/1ps
`include "bpu_config.svh"

module ras (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       pdc_valid,
    input  bpu_pdc_pkg::btb_resp_t     resp,
    input  bpu_ex_pkg::ex_upd_t        upd,
    output logic [`BPU_ADDR_WIDTH-1:0] ret_pc
);
    import bpu_pdc_pkg::*;

    localparam int AW    = `BPU_ADDR_WIDTH;
    localparam int DEPTH = `BPU_RAS_DEPTH;

    logic [AW-1:0] stk [DEPTH];
    logic [AW-1:0] stk_ext [DEPTH+3]; // zero padded below the bottom
    logic          err_flag;          // alternates the recovery depth
    logic          is_ret_pdc;
    logic          is_call_ex;
    logic          is_ret_ex;
    logic [AW-1:0] call_ret_pc;
    logic [1:0]    pop_n;

    assign is_ret_pdc  = resp.hit && (resp.kind == br_ret);
    assign is_call_ex  = upd.valid && (upd.kind == br_call);
    assign is_ret_ex   = upd.valid && (upd.kind == br_ret);
    assign call_ret_pc = upd.pc + AW'(1);

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            stk_ext[i] = stk[i];
        end
        for (int i = DEPTH; i < DEPTH + 3; i++) begin
            stk_ext[i] = '0;
        end
    end

    // entries dropped from the top outside the call case
    always_comb begin
        pop_n = 2'd0;
        if (is_ret_ex && upd.mis_pdc) begin
            if (!err_flag) begin
                pop_n = is_ret_pdc ? 2'd3 : 2'd2;
            end else begin
                pop_n = is_ret_pdc ? 2'd1 : 2'd0;
            end
        end else if (is_ret_pdc) begin
            pop_n = 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < DEPTH; i++) begin
                stk[i] <= '0;
            end
            err_flag <= 1'b0;
        end else if (pdc_valid) begin
            if (is_call_ex) begin
                stk[0] <= call_ret_pc;
                if (!is_ret_pdc) begin // push drops the bottom entry
                    for (int i = 1; i < DEPTH; i++) begin
                        stk[i] <= stk[i-1];
                    end
                end
            end else begin
                for (int i = 0; i < DEPTH; i++) begin
                    stk[i] <= stk_ext[i + int'(pop_n)];
                end
                if (is_ret_ex) begin
                    err_flag <= upd.mis_pdc ? ~err_flag : 1'b0;
                end
            end
        end
    end

    always_comb begin
        ret_pc = '0;
        if (is_ret_pdc) begin
            ret_pc = is_call_ex ? call_ret_pc : stk[0]; // forward call in ex
        end
    end

endmodule

/* rtl/bpu_top.sv */
`timescale 1ns/1ps
`include "bpu_config.svh"

module bpu_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  bpu_pdc_pkg::pdc_req_t  req,
    input  bpu_ex_pkg::ex_upd_t    upd,
    output bpu_pdc_pkg::pdc_pred_t pred
);
    import bpu_pdc_pkg::*;

    localparam int AW = `BPU_ADDR_WIDTH;

    btb_resp_t     bresp;
    logic [AW-1:0] ret_pc;
    logic [AW-1:0] seq_pc;

    assign seq_pc = req.pc + AW'(1);

    btb u_btb (
        .clk  (clk),
        .rstn (rstn),
        .pc   (req.pc),
        .upd  (upd),
        .resp (bresp)
    );

    ras u_ras (
        .clk       (clk),
        .rstn      (rstn),
        .pdc_valid (req.valid),
        .resp      (bresp),
        .upd       (upd),
        .ret_pc    (ret_pc)
    );

    always_comb begin
        pred.hit     = bresp.hit;
        pred.kind    = bresp.kind;
        pred.taken   = 1'b0;
        pred.next_pc = seq_pc; // fall through on miss
        if (bresp.hit) begin
            case (bresp.kind)
                br_ret: begin
                    pred.taken   = 1'b1;
                    pred.next_pc = ret_pc;
                end
                br_jump, br_call: begin
                    pred.taken   = 1'b1;
                    pred.next_pc = bresp.target;
                end
                default: begin
                    pred.taken   = bresp.taken;
                    pred.next_pc = bresp.taken ? bresp.target : seq_pc;
                end
            endcase
        end
    end

endmodule

/* dv/bpu_tb.sv */
`timescale 1ns/1ps
`include "bpu_config.svh"

module bpu_tb;
    import bpu_pdc_pkg::*;
    import bpu_ex_pkg::*;

    localparam int AW         = `BPU_ADDR_WIDTH;
    localparam int IW         = `BPU_BTB_IDX_BITS;
    localparam int DEPTH      = `BPU_RAS_DEPTH;
    localparam int BTB_N      = 1 << IW;
    localparam int CLK_PERIOD = 40;

    typedef struct {
        int        num;
        pdc_req_t  req;
        ex_upd_t   upd;
        pdc_pred_t exp;
    } vec_t;

    logic      clk;
    logic      rstn;
    pdc_req_t  req;
    ex_upd_t   upd;
    pdc_pred_t pred;

    vec_t vecs[$];
    bit   loaded;
    int   err_cnt;
    int   pass_tests;
    int   fail_tests;

    // reference model state
    logic          m_vld [BTB_N];
    logic [AW-IW-1:0] m_tag [BTB_N];
    br_kind_e      m_kind [BTB_N];
    logic [1:0]    m_ctr [BTB_N];
    logic [AW-1:0] m_tgt [BTB_N];
    logic [AW-1:0] m_stk [DEPTH];
    logic          m_flag;

    bpu_top uut (
        .clk  (clk),
        .rstn (rstn),
        .req  (req),
        .upd  (upd),
        .pred (pred)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        wait (loaded);
        #((vecs.size() + 20) * CLK_PERIOD);
        $display("timeout: the run did not finish in the expected number of cycles");
        $display("Test failures found");
        $finish;
    end

    task automatic load_vectors(output bit ok);
        int           fd;
        int           n;
        string        line;
        vec_t         v;
        int           num;
        logic [31:0]  rv, rpc, uv, upc, uk, ut, utgt, um, eh, ek, et, enx;
        ok = 1'b0;
        fd = $fopen("dv/bpu_tests.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                if ($fgets(line, fd) == 0) break;
                n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h", num,
                            rv, rpc, uv, upc, uk, ut, utgt, um, eh, ek, et, enx);
                if (n == 13) begin // comment and blank lines skipped
                    v.num         = num;
                    v.req.valid   = rv[0];
                    v.req.pc      = rpc[AW-1:0];
                    v.upd.valid   = uv[0];
                    v.upd.pc      = upc[AW-1:0];
                    v.upd.kind    = br_kind_e'(uk[1:0]);
                    v.upd.taken   = ut[0];
                    v.upd.target  = utgt[AW-1:0];
                    v.upd.mis_pdc = um[0];
                    v.exp.hit     = eh[0];
                    v.exp.kind    = br_kind_e'(ek[1:0]);
                    v.exp.taken   = et[0];
                    v.exp.next_pc = enx[AW-1:0];
                    vecs.push_back(v);
                end
            end
            $fclose(fd);
        end
    endtask

    function automatic pdc_pred_t model_predict(input pdc_req_t r, input ex_upd_t u);
        logic [IW-1:0] i;
        logic          hit;
        logic [AW-1:0] seq;
        pdc_pred_t     p;
        i   = r.pc[IW-1:0];
        hit = m_vld[i] && (m_tag[i] == r.pc[AW-1:IW]);
        seq = r.pc + AW'(1);
        p.hit     = hit;
        p.kind    = hit ? m_kind[i] : br_cond;
        p.taken   = 1'b0;
        p.next_pc = seq;
        if (hit) begin
            p.taken = 1'b1;
            if (m_kind[i] == br_ret) begin
                p.next_pc = (u.valid && u.kind == br_call) ? u.pc + AW'(1) : m_stk[0];
            end else if (m_kind[i] != br_cond) begin
                p.next_pc = m_tgt[i];
            end else begin
                p.taken   = m_ctr[i][1];
                p.next_pc = m_ctr[i][1] ? m_tgt[i] : seq;
            end
        end
        return p;
    endfunction

    task automatic model_pop(input int n);
        for (int i = 0; i < DEPTH; i++) begin
            m_stk[i] = (i + n < DEPTH) ? m_stk[i+n] : '0;
        end
    endtask

    // state change at the rising edge
    task automatic model_update(input pdc_req_t r, input ex_upd_t u);
        logic [IW-1:0] ri;
        logic [IW-1:0] ui;
        logic          ret_pdc;
        logic          hit_u;
        ri      = r.pc[IW-1:0];
        ui      = u.pc[IW-1:0];
        ret_pdc = m_vld[ri] && (m_tag[ri] == r.pc[AW-1:IW]) && (m_kind[ri] == br_ret);
        hit_u   = m_vld[ui] && (m_tag[ui] == u.pc[AW-1:IW]);
        if (r.valid) begin
            if (u.valid && u.kind == br_call) begin
                if (!ret_pdc) begin
                    for (int i = DEPTH - 1; i > 0; i--) m_stk[i] = m_stk[i-1];
                end
                m_stk[0] = u.pc + AW'(1);
            end else if (u.valid && u.kind == br_ret && !u.mis_pdc) begin
                m_flag = 1'b0;
                if (ret_pdc) model_pop(1);
            end else if (u.valid && u.kind == br_ret) begin
                if (!m_flag) model_pop(ret_pdc ? 3 : 2);
                else model_pop(ret_pdc ? 1 : 0);
                m_flag = !m_flag;
            end else if (ret_pdc) begin
                model_pop(1);
            end
        end
        if (u.valid && hit_u) begin
            if (u.kind != br_cond || u.taken) begin
                m_tgt[ui]  = u.target;
                m_kind[ui] = u.kind;
            end
            if (u.kind == br_cond) begin
                if (u.taken && m_ctr[ui] != 2'd3) m_ctr[ui] = m_ctr[ui] + 2'd1;
                if (!u.taken && m_ctr[ui] != 2'd0) m_ctr[ui] = m_ctr[ui] - 2'd1;
            end
        end else if (u.valid && (u.kind != br_cond || u.taken)) begin
            m_vld[ui]  = 1'b1;
            m_tag[ui]  = u.pc[AW-1:IW];
            m_kind[ui] = u.kind;
            m_ctr[ui]  = 2'b10;
            m_tgt[ui]  = u.target;
        end
    endtask

    // hit, kind and taken here, next_pc has its own check
    task automatic check_pred(input string name, input pdc_pred_t exp, input pdc_pred_t act);
        if ({act.hit, act.kind, act.taken} !== {exp.hit, exp.kind, exp.taken}) begin
            $display("CHECK FAILED at %0t ns: %s expected %h actual %h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_addr(input string name, input logic [AW-1:0] exp,
                              input logic [AW-1:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t ns: %s expected %h actual %h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic close_test(input int num, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_tests++;
            $display("test %0d passed", num);
        end else begin
            fail_tests++;
            $display("test %0d failed with %0d errors", num, err_cnt - errs_before);
        end
    endtask

    task automatic run_vectors();
        pdc_pred_t mp;
        int        cur;
        int        errs_before;
        cur         = vecs[0].num;
        errs_before = 0;
        for (int k = 0; k < vecs.size(); k++) begin
            if (vecs[k].num != cur) begin
                close_test(cur, errs_before);
                cur         = vecs[k].num;
                errs_before = err_cnt;
            end
            @(posedge clk);
            #2;
            req = vecs[k].req;
            upd = vecs[k].upd;
            mp  = model_predict(vecs[k].req, vecs[k].upd);
            if (mp !== vecs[k].exp) begin
                $display("test %0d vector %0d: the file expects %h but the reference model gives %h",
                         cur, k + 1, vecs[k].exp, mp);
                err_cnt++;
            end
            #(CLK_PERIOD - 4);
            check_pred("pred", vecs[k].exp, pred);
            check_addr("pred.next_pc", vecs[k].exp.next_pc, pred.next_pc);
            model_update(vecs[k].req, vecs[k].upd);
        end
        close_test(cur, errs_before);
    endtask

    initial begin : main
        bit ok;
        rstn = 1'b0;
        req  = '0;
        upd  = '0;
        for (int i = 0; i < BTB_N; i++) begin
            m_vld[i]  = 1'b0;
            m_tag[i]  = '0;
            m_kind[i] = br_cond;
            m_ctr[i]  = 2'b00;
            m_tgt[i]  = '0;
        end
        for (int i = 0; i < DEPTH; i++) m_stk[i] = '0;
        m_flag = 1'b0;
        load_vectors(ok);
        loaded = 1'b1;
        if (!ok || vecs.size() == 0) begin
            $display("could not read any vectors from dv/bpu_tests.txt");
            $display("Test failures found");
            $finish;
        end else begin
            repeat (3) @(posedge clk);
            #2;
            rstn = 1'b1;
            run_vectors();
            $display("tests passed: %0d, tests failed: %0d", pass_tests, fail_tests);
            if (fail_tests == 0 && err_cnt == 0) begin
                $display("All tests passed!");
            end else begin
                $display("Test failures found");
            end
            $finish;
        end
    end

endmodule

/* bpu.f */
+incdir+rtl
rtl/bpu_pdc_pkg.sv
rtl/bpu_ex_pkg.sv
rtl/btb.sv
rtl/ras.sv
rtl/bpu_top.sv
dv/bpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= bpu_tb
FILELIST  ?= bpu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG"

test:
	$(VERILATOR) --binary --timing --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "simulation PASSED"; \
	else \
		echo "simulation FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/bpu_tests.txt */
# test(dec) req.valid req.pc upd.valid upd.pc upd.kind upd.taken upd.target upd.mis_pdc
# then expected pred.hit pred.kind pred.taken pred.next_pc; all but test in hex
1 1 100 0 0 0 0 0 0 0 0 0 101
1 1 2345 0 0 0 0 0 0 0 0 0 2346
2 1 200 1 200 1 1 300 0 0 0 0 201
2 1 200 1 210 2 1 400 0 1 1 1 300
2 1 210 1 220 0 0 500 0 1 2 1 400
2 1 220 0 0 0 0 0 0 0 0 0 221
3 1 230 1 230 0 1 280 0 0 0 0 231
3 1 230 1 230 0 0 280 0 1 0 1 280
3 1 230 1 230 0 0 280 0 1 0 0 231
3 1 230 1 230 0 1 280 0 1 0 0 231
3 1 230 1 230 0 1 280 0 1 0 0 231
3 1 230 1 230 0 1 280 0 1 0 1 280
3 1 230 1 230 0 0 280 0 1 0 1 280
3 1 230 0 0 0 0 0 0 1 0 1 280
4 0 0 1 241 3 1 0 0 0 0 0 1
4 1 10 1 505 2 1 900 0 0 0 0 11
4 1 11 1 606 2 1 900 0 0 0 0 12
4 1 12 1 707 2 1 900 0 0 0 0 13
4 1 241 0 0 0 0 0 0 1 3 1 708
4 1 241 0 0 0 0 0 0 1 3 1 607
4 1 241 1 808 2 1 900 0 1 3 1 809
4 1 241 0 0 0 0 0 0 1 3 1 809
4 1 241 0 0 0 0 0 0 1 3 1 211
5 1 2a 1 f9 2 1 900 0 0 0 0 2b
5 1 2a 1 fa 2 1 900 0 0 0 0 2b
5 1 2a 1 fb 2 1 900 0 0 0 0 2b
5 1 2a 1 fc 2 1 900 0 0 0 0 2b
5 1 2a 1 fd 2 1 900 0 0 0 0 2b
5 1 2a 1 242 3 1 0 1 0 0 0 2b
5 1 241 1 242 3 1 0 1 1 3 1 fc
5 1 2a 1 fe 2 1 900 0 0 0 0 2b
5 1 2a 1 f8 2 1 900 0 0 0 0 2b
5 1 2a 1 242 3 1 0 1 0 0 0 2b
5 1 2a 1 242 3 1 0 0 0 0 0 2b
5 1 241 1 242 3 1 0 1 1 3 1 fb
5 1 241 0 0 0 0 0 0 1 3 1 0
6 1 2a 1 1010 2 1 900 0 0 0 0 2b
6 1 2a 1 1011 2 1 900 0 0 0 0 2b
6 1 2a 1 1012 2 1 900 0 0 0 0 2b
6 1 2a 1 1013 2 1 900 0 0 0 0 2b
6 1 2a 1 1014 2 1 900 0 0 0 0 2b
6 1 2a 1 1015 2 1 900 0 0 0 0 2b
6 1 2a 1 1016 2 1 900 0 0 0 0 2b
6 1 2a 1 1017 2 1 900 0 0 0 0 2b
6 1 2a 1 1018 2 1 900 0 0 0 0 2b
6 1 2a 1 1019 2 1 900 0 0 0 0 2b
6 1 2a 1 101a 2 1 900 0 0 0 0 2b
6 1 2a 1 101b 2 1 900 0 0 0 0 2b
6 1 2a 1 101c 2 1 900 0 0 0 0 2b
6 1 2a 1 101d 2 1 900 0 0 0 0 2b
6 1 2a 1 101e 2 1 900 0 0 0 0 2b
6 1 2a 1 101f 2 1 900 0 0 0 0 2b
6 1 2a 1 1020 2 1 900 0 0 0 0 2b
6 1 241 1 242 3 1 0 1 1 3 1 1021
6 1 241 1 242 3 1 0 1 1 3 1 1020
6 1 241 1 242 3 1 0 1 1 3 1 101d
6 1 241 1 242 3 1 0 1 1 3 1 101c
6 1 241 1 242 3 1 0 1 1 3 1 1019
6 1 241 1 242 3 1 0 1 1 3 1 1018
6 1 241 1 242 3 1 0 1 1 3 1 1015
6 0 241 1 1025 2 1 900 0 1 3 1 1026
6 1 241 0 0 0 0 0 0 1 3 1 1014
6 1 241 0 0 0 0 0 0 1 3 1 1013
6 1 241 0 0 0 0 0 0 1 3 1 1012
6 1 241 0 0 0 0 0 0 1 3 1 0
